// ==== include/s18_config.svh ====
// Memory map constants for the System 18 style address decoder
// Base bytes and masks compare against word address bits 23:16
// I/O offsets are decoded from word address bits 4:1
`ifndef S18_CONFIG_SVH
`define S18_CONFIG_SVH

// Number of programmable regions
`define S18_REGIONS 8

// Reset values of the base bytes
`define S18_BASE0 8'h00
`define S18_BASE1 8'h08
`define S18_BASE2 8'h10
`define S18_BASE3 8'hff
`define S18_BASE4 8'h40
`define S18_BASE5 8'h44
`define S18_BASE6 8'h84
`define S18_BASE7 8'hc4

// Compare masks, ROM regions 512 kB, VRAM 128 kB, others 64 kB
`define S18_MASK0 8'hf8
`define S18_MASK1 8'hf8
`define S18_MASK2 8'hf8
`define S18_MASK3 8'hff
`define S18_MASK4 8'hfe
`define S18_MASK5 8'hff
`define S18_MASK6 8'hff
`define S18_MASK7 8'hff

// Region indices, 0 to 2 are ROM
`define S18_REG_RAM  3
`define S18_REG_VRAM 4
`define S18_REG_ORAM 5
`define S18_REG_PAL  6
`define S18_REG_IO   7

// I/O read offsets
`define S18_IO_P1   4'd0
`define S18_IO_P2   4'd1
`define S18_IO_SYS  4'd2
`define S18_IO_DSWA 4'd3
`define S18_IO_DSWB 4'd4

// I/O write offsets
`define S18_IO_CTRL     4'd8
`define S18_IO_TBANK_LO 4'd9
`define S18_IO_TBANK_HI 4'd10

`endif

// ==== hw/s18_pkg.sv ====
// Shared bus types for the System 18 decode logic
// Addresses are 68000 word addresses, bit 0 is never present
`default_nettype none

package s18_pkg;

    // Word address as seen on the bus pins
    typedef logic [23:1] bus_addr_t;

    // Data bus word
    typedef logic [15:0] word_t;

    // Register byte or cabinet input byte
    typedef logic [7:0] byte_t;

    // Index of one of the eight regions
    typedef logic [2:0] region_t;

    // One-hot region hit, bit n for region n
    typedef logic [7:0] active_t;

    // Chip-select FSM
    // SELECT waits for a chip select to register
    // HOLD keeps it until the address strobe rises
    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        HOLD
    } bus_state_t;

endpackage

`default_nettype wire

// ==== hw/s18_mapper.sv ====
// Programmable region mapper with eight base registers
// Lowest matching region wins, unmatched accesses go to the mapper registers
// Only the low byte of a mapper write is stored
`timescale 1ns/1ps
`default_nettype none
`include "s18_config.svh"

module s18_mapper (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire s18_pkg::bus_addr_t addr,
    input  wire s18_pkg::word_t    cpu_dout,
    input  wire logic              ldsn,
    input  wire logic              rnw,
    input  wire logic              map_cs,
    output s18_pkg::active_t       active,
    output logic                   none,
    output s18_pkg::word_t         mapper_dout
);
    import s18_pkg::*;

    // Reset values and compare masks per region
    localparam byte_t base_def [`S18_REGIONS] = '{
        `S18_BASE0, `S18_BASE1, `S18_BASE2, `S18_BASE3,
        `S18_BASE4, `S18_BASE5, `S18_BASE6, `S18_BASE7
    };
    localparam byte_t mask_def [`S18_REGIONS] = '{
        `S18_MASK0, `S18_MASK1, `S18_MASK2, `S18_MASK3,
        `S18_MASK4, `S18_MASK5, `S18_MASK6, `S18_MASK7
    };

    byte_t   base [`S18_REGIONS];
    active_t hit;
    region_t reg_idx;
    logic    map_we;

    // Register index in mapper space
    assign reg_idx = addr[3:1];

    // Low byte write while selected
    assign map_we = map_cs && !rnw && !ldsn;

    // Masked compare of the upper address byte
    always_comb begin
        for (int i = 0; i < `S18_REGIONS; i++) begin
            hit[i] = ((addr[23:16] ^ base[i]) & mask_def[i]) == 8'h00;
        end
    end

    // Priority scan, first hit from region 0 up blocks the rest
    always_comb begin
        logic found;
        found  = 1'b0;
        active = '0;
        for (int i = 0; i < `S18_REGIONS; i++) begin
            active[i] = hit[i] && !found;
            found     = found || hit[i];
        end
    end

    assign none = ~|hit;

    // Base registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `S18_REGIONS; i++) begin
                base[i] <= base_def[i];
            end
        end else if (map_we) begin
            base[reg_idx] <= cpu_dout[7:0];
        end
    end

    // Upper byte reads as all ones
    assign mapper_dout = {8'hff, base[reg_idx]};

    // At most one region reported per access
    a_active_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(active)
    ) else $error("mapper active vector not one-hot");

endmodule

`default_nettype wire

// ==== hw/s18_chipsel.sv ====
// Registered chip selects for the System 18 memory map
// ROM and RAM completion follows rom_ok and ram_ok through sdram_ok
// A ROM write never selects anything and waits forever
`timescale 1ns/1ps
`default_nettype none
`include "s18_config.svh"

module s18_chipsel (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire s18_pkg::bus_addr_t addr,
    input  wire logic              asn,
    input  wire logic              udsn,
    input  wire logic              ldsn,
    input  wire logic              rnw,
    input  wire s18_pkg::active_t  active,
    input  wire logic              none,
    input  wire logic              rom_ok,
    input  wire logic              ram_ok,
    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic                   vram_cs,
    output logic                   char_cs,
    output logic                   objram_cs,
    output logic                   pal_cs,
    output logic                   io_cs,
    output logic                   map_cs,
    output logic                   ready
);
    import s18_pkg::*;

    bus_state_t state;
    logic       bus_low;
    logic       access;
    logic       load_en;
    logic       any_cs;
    logic       fast_cs;
    logic       slow_cs;
    logic       sdram_ok;
    logic [7:0] cs_vec;
    logic [7:0] dec_vec;

    // Either data strobe active
    assign bus_low = !(udsn && ldsn);
    // Reads may start before the data strobes fall
    assign access  = !asn && (bus_low || rnw);

    // Decoded selects, same bit order as cs_vec
    // VRAM region splits by address bit 16
    assign dec_vec = {
        |active[2:0] && rnw,
        active[`S18_REG_RAM] && bus_low,
        active[`S18_REG_VRAM] && !addr[16] && bus_low,
        active[`S18_REG_VRAM] && addr[16],
        active[`S18_REG_ORAM],
        active[`S18_REG_PAL],
        active[`S18_REG_IO],
        none
    };

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, map_cs};
    assign any_cs = |cs_vec;

    // Latch on access start, or retry while a RAM select waits for a strobe
    assign load_en = access && ((state == IDLE) || (state == SELECT && !any_cs));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (access) begin
                        state <= SELECT;
                    end
                end
                SELECT: begin
                    if (asn) begin
                        state <= IDLE;
                    end else if (any_cs) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (asn) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Chip select registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, map_cs} <= '0;
        end else if (asn) begin
            {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, map_cs} <= '0;
        end else if (load_en) begin
            {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, map_cs} <= dec_vec;
        end
    end

    // Internal memories answer at once
    assign fast_cs = char_cs || objram_cs || pal_cs || io_cs || map_cs;
    assign slow_cs = rom_cs || ram_cs || vram_cs;

    // Sticky until the access ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_ok <= 1'b0;
            ready    <= 1'b0;
        end else if (asn) begin
            sdram_ok <= 1'b0;
            ready    <= 1'b0;
        end else begin
            if ((rom_cs && rom_ok) || ((ram_cs || vram_cs) && ram_ok)) begin
                sdram_ok <= 1'b1;
            end
            ready <= fast_cs || (slow_cs && sdram_ok);
        end
    end

    a_cs_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(cs_vec)
    ) else $error("more than one chip select active");

    // A select lives only while the FSM tracks an access with asn low
    a_cs_in_access : assert property (
        @(posedge clk) disable iff (rst)
        any_cs |-> ((state != IDLE) && !$past(asn))
    ) else $error("chip select active outside an access");

endmodule

`default_nettype wire

// ==== hw/s18_cabinet.sv ====
// Cabinet inputs and video control registers in the I/O region
// Only players 1 and 2 are decoded, other offsets read FF
// Writes use the low data byte only
`timescale 1ns/1ps
`default_nettype none
`include "s18_config.svh"

module s18_cabinet (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire s18_pkg::bus_addr_t addr,
    input  wire s18_pkg::word_t    cpu_dout,
    input  wire logic              ldswn,
    input  wire logic              io_cs,
    input  wire s18_pkg::byte_t    joystick1,
    input  wire s18_pkg::byte_t    joystick2,
    input  wire logic [3:0]        coin,
    input  wire logic [1:0]        cab_1p,
    input  wire logic              service,
    input  wire logic              dip_test,
    input  wire s18_pkg::byte_t    dipsw_a,
    input  wire s18_pkg::byte_t    dipsw_b,
    output s18_pkg::byte_t         cab_dout,
    output logic                   flip,
    output logic                   video_en,
    output logic [5:0]             tile_bank
);
    import s18_pkg::*;

    byte_t sys_byte;
    logic  io_we;

    // Coins on top, test switch in bit 0
    assign sys_byte = {coin, cab_1p, service, dip_test};

    // Read port select
    always_comb begin
        case (addr[4:1])
            `S18_IO_P1:   cab_dout = joystick1;
            `S18_IO_P2:   cab_dout = joystick2;
            `S18_IO_SYS:  cab_dout = sys_byte;
            `S18_IO_DSWA: cab_dout = dipsw_a;
            `S18_IO_DSWB: cab_dout = dipsw_b;
            default:      cab_dout = 8'hff;
        endcase
    end

    assign io_we = io_cs && !ldswn;

    // Control and tile bank registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            video_en  <= 1'b0;
            tile_bank <= 6'd0;
        end else if (io_we) begin
            case (addr[4:1])
                `S18_IO_CTRL: begin
                    flip     <= cpu_dout[0];
                    video_en <= cpu_dout[1];
                end
                // Each half is 3 bits wide
                `S18_IO_TBANK_LO: tile_bank[2:0] <= cpu_dout[2:0];
                `S18_IO_TBANK_HI: tile_bank[5:3] <= cpu_dout[2:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/s18_main.sv ====
// Top level of the System 18 bus decode, the CPU is external
// Read data and DTACK are registered, fast regions acknowledge in 2 cycles
// ROM and RAM acknowledge after their ok inputs
`timescale 1ns/1ps
`default_nettype none

module s18_main (
    input  wire logic              clk,
    input  wire logic              rst,
    // 68000 style bus
    input  wire s18_pkg::bus_addr_t addr,
    input  wire s18_pkg::word_t    cpu_dout,
    input  wire logic              asn,
    input  wire logic              udsn,
    input  wire logic              ldsn,
    input  wire logic              rnw,
    output s18_pkg::word_t         cpu_din,
    output logic                   dtackn,
    output logic                   udswn,
    output logic                   ldswn,
    // ROM port
    output logic                   rom_cs,
    output logic [18:1]            rom_addr,
    input  wire s18_pkg::word_t    rom_data,
    input  wire logic              rom_ok,
    // Work RAM and VRAM port
    output logic                   ram_cs,
    output logic                   vram_cs,
    input  wire s18_pkg::word_t    ram_data,
    input  wire logic              ram_ok,
    // Video memories
    output logic                   char_cs,
    output logic                   pal_cs,
    output logic                   objram_cs,
    input  wire s18_pkg::word_t    char_dout,
    input  wire s18_pkg::word_t    pal_dout,
    input  wire s18_pkg::word_t    obj_dout,
    // Cabinet
    input  wire s18_pkg::byte_t    joystick1,
    input  wire s18_pkg::byte_t    joystick2,
    input  wire logic [3:0]        coin,
    input  wire logic [1:0]        cab_1p,
    input  wire logic              service,
    input  wire logic              dip_test,
    input  wire s18_pkg::byte_t    dipsw_a,
    input  wire s18_pkg::byte_t    dipsw_b,
    output logic                   flip,
    output logic                   video_en,
    output logic [5:0]             tile_bank
);
    import s18_pkg::*;

    active_t active;
    word_t   mapper_dout;
    byte_t   cab_dout;
    logic    none;
    logic    io_cs;
    logic    map_cs;
    logic    ready;

    // Write strobes
    assign udswn = rnw | udsn;
    assign ldswn = rnw | ldsn;

    // ROM word address, 512 kB per ROM region
    assign rom_addr = addr[18:1];

    s18_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .ldsn        (ldsn),
        .rnw         (rnw),
        .map_cs      (map_cs),
        .active      (active),
        .none        (none),
        .mapper_dout (mapper_dout)
    );

    s18_chipsel u_chipsel (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .asn       (asn),
        .udsn      (udsn),
        .ldsn      (ldsn),
        .rnw       (rnw),
        .active    (active),
        .none      (none),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .objram_cs (objram_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .map_cs    (map_cs),
        .ready     (ready)
    );

    s18_cabinet u_cabinet (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .cpu_dout  (cpu_dout),
        .ldswn     (ldswn),
        .io_cs     (io_cs),
        .joystick1 (joystick1),
        .joystick2 (joystick2),
        .coin      (coin),
        .cab_1p    (cab_1p),
        .service   (service),
        .dip_test  (dip_test),
        .dipsw_a   (dipsw_a),
        .dipsw_b   (dipsw_b),
        .cab_dout  (cab_dout),
        .flip      (flip),
        .video_en  (video_en),
        .tile_bank (tile_bank)
    );

    // Read data, fixed priority, sampled every clock
    always_ff @(posedge clk) begin
        if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (io_cs) begin
            cpu_din <= {8'hff, cab_dout};
        end else if (map_cs) begin
            cpu_din <= mapper_dout;
        end else begin
            cpu_din <= 16'hffff;
        end
    end

    // DTACK one edge after ready, released with asn
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn <= 1'b1;
        end else if (asn) begin
            dtackn <= 1'b1;
        end else if (ready) begin
            dtackn <= 1'b0;
        end
    end

    // Acknowledge only inside a live access, selects drop with asn
    a_dtack_cs : assert property (
        @(posedge clk) disable iff (rst)
        !dtackn |-> (rom_cs || ram_cs || vram_cs || char_cs ||
                     pal_cs || objram_cs || io_cs || map_cs)
    ) else $error("dtackn low without an active chip select");

endmodule

`default_nettype wire

// ==== sim/tb_s18_main.sv ====
// Directed testbench for the System 18 bus decode top level
// Bus master is modeled by tasks, ROM, RAM and the video memories by simple models
// ROM and RAM ok latency is random in 0 to 7 cycles from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_s18_main;
    import s18_pkg::*;

    // Run limit, far above the few hundred cycles that the tests need
    localparam int TIMEOUT_CYCLES = 4000;
    // Per access DTACK limit
    localparam int DTACK_LIMIT = 64;

    logic       clk;
    logic       rst;
    bus_addr_t  addr;
    word_t      cpu_dout;
    logic       asn;
    logic       udsn;
    logic       ldsn;
    logic       rnw;
    word_t      cpu_din;
    logic       dtackn;
    logic       udswn;
    logic       ldswn;
    logic       rom_cs;
    logic [18:1] rom_addr;
    word_t      rom_data;
    logic       rom_ok;
    logic       ram_cs;
    logic       vram_cs;
    word_t      ram_data;
    logic       ram_ok;
    logic       char_cs;
    logic       pal_cs;
    logic       objram_cs;
    word_t      char_dout;
    word_t      pal_dout;
    word_t      obj_dout;
    byte_t      joystick1;
    byte_t      joystick2;
    logic [3:0] coin;
    logic [1:0] cab_1p;
    logic       service;
    logic       dip_test;
    byte_t      dipsw_a;
    byte_t      dipsw_b;
    logic       flip;
    logic       video_en;
    logic [5:0] tile_bank;

    integer     seed;
    int         errors;
    int         checks;
    int         tests;
    int         cycle_count;
    int         ok_lat;
    int         rom_wait;
    int         ram_wait;
    logic [5:0] last_cs;
    logic [18:1] last_rom_addr;
    logic [1:0] last_wstb;
    word_t      ram_mem [0:2047];
    logic [10:0] ram_idx;

    s18_main uut (
        .clk(clk), .rst(rst), .addr(addr), .cpu_dout(cpu_dout), .asn(asn),
        .udsn(udsn), .ldsn(ldsn), .rnw(rnw), .cpu_din(cpu_din), .dtackn(dtackn),
        .udswn(udswn), .ldswn(ldswn), .rom_cs(rom_cs), .rom_addr(rom_addr),
        .rom_data(rom_data), .rom_ok(rom_ok), .ram_cs(ram_cs), .vram_cs(vram_cs),
        .ram_data(ram_data), .ram_ok(ram_ok), .char_cs(char_cs), .pal_cs(pal_cs),
        .objram_cs(objram_cs), .char_dout(char_dout), .pal_dout(pal_dout),
        .obj_dout(obj_dout), .joystick1(joystick1), .joystick2(joystick2),
        .coin(coin), .cab_1p(cab_1p), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .flip(flip), .video_en(video_en),
        .tile_bank(tile_bank)
    );

    always #10 clk = ~clk;

    // ROM contents as a function of the word address
    function automatic word_t rom_word(input logic [18:1] a);
        rom_word = a[16:1] ^ {a[18:17], a[18:17], 12'h000} ^ 16'hc3a5;
    endfunction

    // Fast memory patterns
    assign char_dout = addr[16:1] ^ 16'hc0de;
    assign pal_dout  = addr[16:1] ^ 16'h9a1e;
    assign obj_dout  = addr[16:1] ^ 16'h0b1e;

    assign rom_data = rom_word(rom_addr);

    // VRAM in the upper half of the RAM model
    assign ram_idx  = {vram_cs, addr[10:1]};
    assign ram_data = ram_mem[ram_idx];

    // ROM ok after ok_lat cycles of select, held while selected
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= 0;
        end else if (rom_wait >= ok_lat) begin
            rom_ok <= 1'b1;
        end else begin
            rom_wait <= rom_wait + 1;
        end
    end

    // RAM ok and byte writes
    always @(posedge clk) begin
        if (!(ram_cs || vram_cs)) begin
            ram_ok   <= 1'b0;
            ram_wait <= 0;
        end else begin
            if (ram_wait >= ok_lat) begin
                ram_ok <= 1'b1;
            end else begin
                ram_wait <= ram_wait + 1;
            end
            if (!udswn) begin
                ram_mem[ram_idx][15:8] <= cpu_dout[15:8];
            end
            if (!ldswn) begin
                ram_mem[ram_idx][7:0] <= cpu_dout[7:0];
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run passed %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // One bus cycle, lag counts edges from the first asn low sample to dtackn low
    task automatic run_cycle(input logic [23:0] baddr, input logic rd, input word_t wdata,
                             input logic us_n, input logic ls_n,
                             output word_t rdata, output int lag);
        int n;
        ok_lat = $unsigned($random(seed)) % 8;
        @(posedge clk);
        addr     <= baddr[23:1];
        cpu_dout <= wdata;
        rnw      <= rd;
        asn      <= 1'b0;
        udsn     <= us_n;
        ldsn     <= ls_n;
        @(negedge clk);
        n = 1;
        while (dtackn && n < DTACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (dtackn) begin
            $display("Bus error: no DTACK within %0d cycles at address %h", DTACK_LIMIT, baddr);
            errors++;
        end
        rdata         = cpu_din;
        lag           = n - 2;
        last_cs       = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs};
        last_rom_addr = rom_addr;
        last_wstb     = {udswn, ldswn};
        // Release in the cycle after DTACK
        @(posedge clk);
        asn  <= 1'b1;
        udsn <= 1'b1;
        ldsn <= 1'b1;
        rnw  <= 1'b1;
        // DTACK and selects drop on the edge that samples asn high
        @(posedge clk);
        @(negedge clk);
        check(dtackn, 1, "dtackn after asn release");
        check({rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, uut.io_cs, uut.map_cs},
              0, "chip selects after asn release");
        @(posedge clk);
    endtask

    task automatic read_word(input logic [23:0] baddr, output word_t data, output int lag);
        run_cycle(baddr, 1'b1, 16'h0000, 1'b0, 1'b0, data, lag);
    endtask

    task automatic write_word(input logic [23:0] baddr, input word_t data,
                              input logic us_n, input logic ls_n, output int lag);
        word_t unused;
        run_cycle(baddr, 1'b0, data, us_n, ls_n, unused, lag);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_reset();
        int    e;
        word_t d;
        int    lag;
        e = errors;
        @(negedge clk);
        check({rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, uut.io_cs, uut.map_cs},
              0, "chip selects after reset");
        check(dtackn, 1, "dtackn after reset");
        check({flip, video_en, tile_bank}, 0, "cabinet registers after reset");
        // Unmapped 20xxxx, register 4
        read_word(24'h200008, d, lag);
        check(d, 16'hff40, "mapper register 4 default");
        check(lag, 2, "mapper read DTACK delay");
        report_test("reset", e);
    endtask

    task automatic rom_ram_access();
        int          e;
        int          lag;
        word_t       d;
        word_t       w;
        logic [31:0] r;
        logic [23:0] a;
        e = errors;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            a = {5'd0, r[18:1], 1'b0};
            read_word(a, d, lag);
            check(d, rom_word(a[18:1]), "ROM read data");
            check(last_rom_addr, a[18:1], "ROM word address");
            check(last_cs, 6'b100000, "ROM chip select");
            // ok, then sdram_ok, ready and DTACK one edge each
            check(lag, ok_lat + 4, "ROM DTACK delay");
        end
        w = $random(seed);
        write_word(24'hff0100, w, 1'b0, 1'b0, lag);
        check(last_cs, 6'b010000, "RAM write chip select");
        check(lag, ok_lat + 4, "RAM write DTACK delay");
        read_word(24'hff0100, d, lag);
        check(d, w, "RAM read back");
        // Byte lanes
        write_word(24'hff0200, 16'h1234, 1'b0, 1'b0, lag);
        write_word(24'hff0200, 16'hab00, 1'b0, 1'b1, lag);
        check(last_wstb, 2'b01, "upper byte write strobes");
        read_word(24'hff0200, d, lag);
        check(d, 16'hab34, "upper byte write");
        write_word(24'hff0200, 16'h00cd, 1'b1, 1'b0, lag);
        check(last_wstb, 2'b10, "lower byte write strobes");
        read_word(24'hff0200, d, lag);
        check(d, 16'habcd, "lower byte write");
        report_test("rom_ram", e);
    endtask

    task automatic remap_region();
        int    e;
        int    lag;
        word_t d;
        e = errors;
        write_word(24'h200008, 16'h0050, 1'b1, 1'b0, lag);
        check(lag, 2, "mapper write DTACK delay");
        read_word(24'h200008, d, lag);
        check(d, 16'hff50, "mapper register 4 after write");
        // VRAM half at 50xxxx
        write_word(24'h500010, 16'h1357, 1'b0, 1'b0, lag);
        check(last_cs, 6'b001000, "VRAM write chip select");
        read_word(24'h500010, d, lag);
        check(d, 16'h1357, "VRAM read back");
        check(last_cs, 6'b001000, "VRAM read chip select");
        // Character RAM half at 51xxxx, address bit 16 lands in pattern bit 15
        read_word(24'h510020, d, lag);
        check(d, 16'h8010 ^ 16'hc0de, "char RAM read data");
        check(last_cs, 6'b000100, "char RAM chip select");
        check(lag, 2, "char RAM DTACK delay");
        // Old base now unmapped, register 3 holds FF
        read_word(24'h400006, d, lag);
        check(d, 16'hffff, "old VRAM address in mapper space");
        check(last_cs, 6'b000000, "no memory select at old address");
        report_test("remap", e);
    endtask

    task automatic cabinet_reads();
        int    e;
        int    lag;
        word_t d;
        e = errors;
        read_word(24'hc40000, d, lag);
        check(d, {8'hff, joystick1}, "P1 read");
        check(lag, 2, "I/O read DTACK delay");
        read_word(24'hc40002, d, lag);
        check(d, {8'hff, joystick2}, "P2 read");
        read_word(24'hc40004, d, lag);
        check(d, {8'hff, coin, cab_1p, service, dip_test}, "SYS read");
        read_word(24'hc40006, d, lag);
        check(d, {8'hff, dipsw_a}, "DSWA read");
        read_word(24'hc40008, d, lag);
        check(d, {8'hff, dipsw_b}, "DSWB read");
        report_test("cabinet_reads", e);
    endtask

    task automatic cabinet_writes();
        int    e;
        int    lag;
        word_t d;
        e = errors;
        write_word(24'hc40010, 16'h0003, 1'b1, 1'b0, lag);
        check(lag, 2, "I/O write DTACK delay");
        check({flip, video_en}, 2'b11, "control write flip and video");
        write_word(24'hc40010, 16'h0002, 1'b1, 1'b0, lag);
        check({flip, video_en}, 2'b01, "control write video only");
        write_word(24'hc40012, 16'h0005, 1'b1, 1'b0, lag);
        write_word(24'hc40014, 16'h0006, 1'b1, 1'b0, lag);
        check(tile_bank, {3'd6, 3'd5}, "tile bank halves");
        // Remaining fast regions
        read_word(24'h840040, d, lag);
        check(d, 16'h0020 ^ 16'h9a1e, "palette read data");
        check(last_cs, 6'b000001, "palette chip select");
        check(lag, 2, "palette DTACK delay");
        read_word(24'h440080, d, lag);
        check(d, 16'h0040 ^ 16'h0b1e, "object RAM read data");
        check(last_cs, 6'b000010, "object RAM chip select");
        check(lag, 2, "object RAM DTACK delay");
        report_test("cabinet_writes", e);
    endtask

    initial begin
        seed        = 32'h8ccb87aa;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        cycle_count = 0;
        ok_lat      = 0;
        rom_wait    = 0;
        ram_wait    = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        addr        = '0;
        cpu_dout    = '0;
        asn         = 1'b1;
        udsn        = 1'b1;
        ldsn        = 1'b1;
        rnw         = 1'b1;
        rom_ok      = 1'b0;
        ram_ok      = 1'b0;
        joystick1   = 8'h3c;
        joystick2   = 8'hc3;
        coin        = 4'ha;
        cab_1p      = 2'b01;
        service     = 1'b1;
        dip_test    = 1'b0;
        dipsw_a     = 8'h5f;
        dipsw_b     = 8'hf6;
        // Fill spans the whole model index
        for (int i = 0; i < 2048; i++) begin
            ram_mem[i] = 16'(i * 7) ^ 16'h5a00;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        check_reset();
        rom_ram_access();
        remap_region();
        cabinet_reads();
        cabinet_writes();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hw/s18_pkg.sv
hw/s18_mapper.sv
hw/s18_chipsel.sv
hw/s18_cabinet.sv
hw/s18_main.sv
sim/tb_s18_main.sv
